// ==== testbench/conv_golden.hex ====
// base pixel values, four per line, pixel 0 (row 0, column 0) first
// then one opcode per line, opcode 7 adds four results in window order, ffff ends
00 20 40 60
80 a0 c0 e0
60 80 a0 c0
e0 00 20 40
c0 e0 00 20
40 60 80 a0
20 40 60 80
a0 c0 e0 00
80 a0 c0 e0
00 20 40 60
e0 00 20 40
60 80 a0 c0
40 60 80 a0
c0 e0 00 20
a0 c0 e0 00
20 40 60 80
// load, then corner window at depth 32
0
7 417 774 b74 ff0
// up and left at the corner change nothing
3
2
7 417 774 b74 ff0
// right seven times stops at column 6
1
1
1
1
1
1
1
7 e74 c57 df0 c74
// down seven times stops at row 6
4
4
4
4
4
4
4
7 df0 974 974 717
2
2
2
7 ff0 11f0 a74 974
3
3
3
7 ff0 ff0 11f0 df0
// depth down to 8, then 16, then back to 32
5
5
5
7 39c 39c 41c 31c
6
7 778 778 878 678
6
6
7 ff0 ff0 11f0 df0
// unused code
b
7 ff0 ff0 11f0 df0
ffff

// ==== filelist.f ====
design/conv_geom_pkg.sv
design/conv_op_pkg.sv
design/op_controller.sv
design/channel_accumulator.sv
design/gaussian_conv.sv
design/conv_core_top.sv
testbench/tb_conv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the conv core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module tb_conv_core \
	-Mdir obj_dir -o tb_conv_core
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/tb_conv_core
status=$?
if [ $status -ne 0 ]; then
	echo "simulation ended with status $status"
	exit $status
fi
exit 0

// ==== testbench/tb_conv_core.sv ====
`timescale 1ns/1ns

module tb_conv_core;
	import conv_geom_pkg::*;
	import conv_op_pkg::*;

	localparam int GOLD_WORDS = 512;
	localparam int N_BYTES    = N_PIX * N_CHAN;

	logic      i_clk;
	logic      i_rst_n;
	logic      i_op_valid;
	op_mode_t  i_op_mode;
	logic      o_op_ready;
	logic      i_in_valid;
	pixel_t    i_in_data;
	logic      o_in_ready;
	logic      o_out_valid;
	out_data_t o_out_data;

	// raw words of the golden file
	logic [15:0] gold [GOLD_WORDS];
	pixel_t      base [N_PIX];
	out_data_t   expect_q [4];
	int          cycle_cnt   = 0;
	int          cycle_limit = 0;
	int          n_ops;
	int          rd_ptr;
	int          seed_ret;
	op_mode_t    op;

	conv_core_top #(
		.ORIGIN_MAX (6)
	) i_dut (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.o_op_ready  (o_op_ready),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	// 4 ns clock
	initial begin
		i_clk = 1'b0;
		forever #2 i_clk = ~i_clk;
	end

	// ------------------------------------------------------------
	// error handling and checks
	// ------------------------------------------------------------
	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_data(input string name, input out_data_t got, input out_data_t exp);
		if (got !== exp)
			stop_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// cycle budget taken from the operation list
	always @(posedge i_clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit != 0 && cycle_cnt >= cycle_limit)
			stop_run("timeout, the operation list did not finish in its cycle budget");
	end

	// ------------------------------------------------------------
	// golden file
	// ------------------------------------------------------------
	// 64 base pixels, then opcodes, conv lines carry four results
	task automatic read_golden();
		int ptr;
		ptr   = N_PIX;
		n_ops = 0;
		$readmemh("testbench/conv_golden.hex", gold);
		for (int i = 0; i < N_PIX; i++)
			base[i] = pixel_t'(gold[i]);
		while (ptr < GOLD_WORDS && gold[ptr] != 16'hffff) begin
			if (op_mode_t'(gold[ptr][3:0]) == OP_CONV)
				ptr = ptr + 5;
			else
				ptr = ptr + 1;
			n_ops++;
		end
		if (ptr >= GOLD_WORDS || n_ops == 0)
			stop_run("golden file is missing, empty or has no end marker");
		// reset, full load at worst 4 cycles a byte, 50 per operation
		cycle_limit = 16 + N_BYTES * 4 + 50 * n_ops;
	endtask

	// ------------------------------------------------------------
	// command side
	// ------------------------------------------------------------
	// no result may show up between convolutions
	task automatic wait_op_ready();
		while (!o_op_ready) begin
			check_flag("o_out_valid", o_out_valid, 1'b0);
			@(negedge i_clk);
		end
	endtask

	// one-cycle request, taken on the next rising edge
	task automatic issue_op(input op_mode_t mode);
		wait_op_ready();
		i_op_valid = 1'b1;
		i_op_mode  = mode;
		@(negedge i_clk);
		i_op_valid = 1'b0;
		check_flag("o_op_ready", o_op_ready, 1'b0);
	endtask

	// channel-major bytes with random gaps
	task automatic load_image();
		int        taken;
		logic      beat_on;
		chan_idx_t ch;
		pix_idx_t  px;
		taken = 0;
		issue_op(OP_LOAD);
		while (taken < N_BYTES) begin
			check_flag("o_in_ready", o_in_ready, 1'b1);
			check_flag("o_op_ready", o_op_ready, 1'b0);
			ch         = chan_idx_t'(taken / N_PIX);
			px         = pix_idx_t'(taken % N_PIX);
			beat_on    = ($urandom % 4) != 0;
			i_in_valid = beat_on;
			i_in_data  = base[px] ^ pixel_t'(ch);
			@(negedge i_clk);
			if (beat_on)
				taken++;
		end
		i_in_valid = 1'b0;
		check_flag("o_in_ready", o_in_ready, 1'b0);
		check_flag("o_op_ready", o_op_ready, 1'b1);
		// stray bytes after the load must be dropped
		i_in_valid = 1'b1;
		i_in_data  = 8'hff;
		repeat (2) @(negedge i_clk);
		i_in_valid = 1'b0;
	endtask

	// shift, depth and unknown codes
	task automatic run_simple_op(input op_mode_t mode);
		issue_op(mode);
		@(negedge i_clk);
		check_flag("o_op_ready", o_op_ready, 1'b1);
	endtask

	// four results, nine cycles apart
	task automatic run_conv();
		int n_out;
		int waited;
		n_out  = 0;
		waited = 0;
		issue_op(OP_CONV);
		while (n_out < 4) begin
			@(negedge i_clk);
			waited++;
			check_flag("o_op_ready", o_op_ready, 1'b0);
			if (o_out_valid) begin
				if (waited != 9 * (n_out + 1))
					stop_run($sformatf("convolution result %0d came %0d cycles late or early",
						n_out, waited - 9 * (n_out + 1)));
				check_data("o_out_data", o_out_data, expect_q[n_out]);
				n_out++;
			end
		end
		@(negedge i_clk);
		check_flag("o_out_valid", o_out_valid, 1'b0);
		check_flag("o_op_ready", o_op_ready, 1'b1);
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		i_rst_n    = 1'b0;
		i_op_valid = 1'b0;
		i_op_mode  = OP_LOAD;
		i_in_valid = 1'b0;
		i_in_data  = '0;
		seed_ret   = $urandom(32'he133a854);
		read_golden();
		repeat (4) @(negedge i_clk);
		i_rst_n = 1'b1;
		@(negedge i_clk);
		// idle state after reset
		check_flag("o_op_ready", o_op_ready, 1'b1);
		check_flag("o_in_ready", o_in_ready, 1'b0);
		check_flag("o_out_valid", o_out_valid, 1'b0);
		rd_ptr = N_PIX;
		for (int k = 0; k < n_ops; k++) begin
			op     = op_mode_t'(gold[rd_ptr][3:0]);
			rd_ptr = rd_ptr + 1;
			if (op == OP_CONV) begin
				for (int i = 0; i < 4; i++)
					expect_q[i] = out_data_t'(gold[rd_ptr + i]);
				rd_ptr = rd_ptr + 4;
				run_conv();
			end else if (op == OP_LOAD) begin
				load_image();
			end else begin
				run_simple_op(op);
			end
		end
		wait_op_ready();
		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

// ==== design/conv_core_top.sv ====
`timescale 1ns/1ns

module conv_core_top #(
	parameter int ORIGIN_MAX = 6
) (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_op_valid,
	input  conv_op_pkg::op_mode_t    i_op_mode,
	output logic                     o_op_ready,
	input  logic                     i_in_valid,
	input  conv_geom_pkg::pixel_t    i_in_data,
	output logic                     o_in_ready,
	output logic                     o_out_valid,
	output conv_geom_pkg::out_data_t o_out_data
);
	import conv_geom_pkg::*;
	import conv_op_pkg::*;

	load_beat_t beat;
	conv_cmd_t  cmd;
	depth_t     depth;
	logic       conv_done;
	pix_idx_t   ctr_idx;
	pix_idx_t   tap_idx;
	map_sum_t   ctr_sum;
	map_sum_t   tap_sum;

	// commands, origin, depth and load sequencing
	op_controller #(
		.ORIGIN_MAX (ORIGIN_MAX)
	) u_ctrl (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_op_ready  (o_op_ready),
		.o_in_ready  (o_in_ready),
		.o_beat      (beat),
		.o_cmd       (cmd),
		.o_depth     (depth),
		.i_conv_done (conv_done)
	);

	// per-group pixel sums
	channel_accumulator u_acc (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_beat    (beat),
		.i_depth   (depth),
		.i_ctr_idx (ctr_idx),
		.i_tap_idx (tap_idx),
		.o_ctr_sum (ctr_sum),
		.o_tap_sum (tap_sum)
	);

	// 3x3 filter over the window
	gaussian_conv u_conv (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_cmd       (cmd),
		.i_ctr_sum   (ctr_sum),
		.i_tap_sum   (tap_sum),
		.o_ctr_idx   (ctr_idx),
		.o_tap_idx   (tap_idx),
		.o_done      (conv_done),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

endmodule

// ==== design/gaussian_conv.sv ====
`timescale 1ns/1ns

module gaussian_conv (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  conv_op_pkg::conv_cmd_t   i_cmd,
	input  conv_geom_pkg::map_sum_t  i_ctr_sum,
	input  conv_geom_pkg::map_sum_t  i_tap_sum,
	output conv_geom_pkg::pix_idx_t  o_ctr_idx,
	output conv_geom_pkg::pix_idx_t  o_tap_idx,
	output logic                     o_done,
	output logic                     o_out_valid,
	output conv_geom_pkg::out_data_t o_out_data
);
	import conv_geom_pkg::*;
	import conv_op_pkg::*;

	conv_state_t state;
	pix_idx_t    org_q;
	logic [1:0]  px_cnt;
	logic [2:0]  tap_cnt;
	conv_acc_t   acc;
	logic [2:0]  row;
	logic [2:0]  col;
	logic [2:0]  nrow;
	logic [2:0]  ncol;
	logic        tap_in;
	logic        tap_dbl;
	conv_acc_t   tap_term;
	conv_acc_t   ctr_term;

	// ------------------------------------------------------------
	// tap addressing
	// ------------------------------------------------------------
	// window order origin, +1, +8, +9
	assign row       = org_q[5:3] + {2'b00, px_cnt[1]};
	assign col       = org_q[2:0] + {2'b00, px_cnt[0]};
	assign o_ctr_idx = {row, col};
	assign o_tap_idx = {nrow, ncol};

	// taps NW N NE W E SW S SE
	always_comb begin
		nrow   = row;
		ncol   = col;
		tap_in = 1'b1;
		// row above or below
		case (tap_cnt)
			3'd0, 3'd1, 3'd2: begin
				nrow   = row - 3'd1;
				tap_in = (row != 3'd0);
			end
			3'd5, 3'd6, 3'd7: begin
				nrow   = row + 3'd1;
				tap_in = (row != 3'(IMG_SIDE - 1));
			end
			default: ;
		endcase
		// column left or right
		case (tap_cnt)
			3'd0, 3'd3, 3'd5: begin
				ncol   = col - 3'd1;
				tap_in = tap_in && (col != 3'd0);
			end
			3'd2, 3'd4, 3'd7: begin
				ncol   = col + 3'd1;
				tap_in = tap_in && (col != 3'(IMG_SIDE - 1));
			end
			default: ;
		endcase
	end

	// edge neighbours weigh 2, corners 1
	assign tap_dbl = (tap_cnt == 3'd1) || (tap_cnt == 3'd3)
		|| (tap_cnt == 3'd4) || (tap_cnt == 3'd6);
	// zero padding outside the image
	assign tap_term = !tap_in ? '0
		: (tap_dbl ? conv_acc_t'({i_tap_sum, 1'b0}) : conv_acc_t'(i_tap_sum));
	// centre x4 rides along with the first tap
	assign ctr_term = (tap_cnt == 3'd0) ? conv_acc_t'({i_ctr_sum, 2'b00}) : '0;

	// ------------------------------------------------------------
	// output
	// ------------------------------------------------------------
	// divide by 16, round on bit 3
	assign o_out_valid = (state == CONV_EMIT);
	assign o_out_data  = out_data_t'(acc[16:4] + {12'd0, acc[3]});
	assign o_done      = o_out_valid && (px_cnt == 2'd3);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state   <= CONV_IDLE;
			org_q   <= '0;
			px_cnt  <= '0;
			tap_cnt <= '0;
			acc     <= '0;
		end else begin
			case (state)
				CONV_IDLE: begin
					if (i_cmd.start) begin
						org_q   <= i_cmd.origin;
						px_cnt  <= '0;
						tap_cnt <= '0;
						acc     <= '0;
						state   <= CONV_TAP;
					end
				end
				CONV_TAP: begin
					acc     <= acc + tap_term + ctr_term;
					tap_cnt <= tap_cnt + 3'd1;
					if (tap_cnt == 3'd7)
						state <= CONV_EMIT;
				end
				CONV_EMIT: begin
					acc <= '0;
					if (px_cnt == 2'd3) begin
						state <= CONV_IDLE;
					end else begin
						px_cnt <= px_cnt + 2'd1;
						state  <= CONV_TAP;
					end
				end
				default: state <= CONV_IDLE;
			endcase
		end
	end

	// a new window starts only after the last result
	start_only_when_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_cmd.start |-> (state == CONV_IDLE));

endmodule

// ==== design/channel_accumulator.sv ====
`timescale 1ns/1ns

module channel_accumulator (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  conv_op_pkg::load_beat_t i_beat,
	input  conv_op_pkg::depth_t     i_depth,
	input  conv_geom_pkg::pix_idx_t i_ctr_idx,
	input  conv_geom_pkg::pix_idx_t i_tap_idx,
	output conv_geom_pkg::map_sum_t o_ctr_sum,
	output conv_geom_pkg::map_sum_t o_tap_sum
);
	import conv_geom_pkg::*;
	import conv_op_pkg::*;

	grp8_sum_t  sum8  [N_PIX];
	grp16_sum_t sum16 [N_PIX];
	grp32_sum_t sum32 [N_PIX];
	logic       grp_first;

	// group 8 always counts, the others by depth
	function automatic map_sum_t depth_sum(input pix_idx_t idx);
		map_sum_t s;
		s = map_sum_t'(sum8[idx]);
		if (i_depth != DEPTH_8)
			s = s + map_sum_t'(sum16[idx]);
		if (i_depth == DEPTH_32)
			s = s + map_sum_t'(sum32[idx]);
		return s;
	endfunction

	// ------------------------------------------------------------
	// load side
	// ------------------------------------------------------------
	// channels 0, 8 and 16 open a group
	// restarting there lets a new load replace the old image
	assign grp_first = (i_beat.channel[2:0] == 3'd0) && (i_beat.channel[4:3] != 2'd3);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < N_PIX; i++) begin
				sum8[i]  <= '0;
				sum16[i] <= '0;
				sum32[i] <= '0;
			end
		end else if (i_beat.valid) begin
			case (i_beat.channel[4:3])
				2'd0: begin
					sum8[i_beat.pixel] <= (grp_first ? '0 : sum8[i_beat.pixel])
						+ grp8_sum_t'(i_beat.data);
				end
				2'd1: begin
					sum16[i_beat.pixel] <= (grp_first ? '0 : sum16[i_beat.pixel])
						+ grp16_sum_t'(i_beat.data);
				end
				// channels 16..31 share the wide array
				default: begin
					sum32[i_beat.pixel] <= (grp_first ? '0 : sum32[i_beat.pixel])
						+ grp32_sum_t'(i_beat.data);
				end
			endcase
		end
	end

	// ------------------------------------------------------------
	// read side
	// ------------------------------------------------------------
	// same-cycle reads for centre and neighbour
	always_comb begin
		o_ctr_sum = depth_sum(i_ctr_idx);
		o_tap_sum = depth_sum(i_tap_idx);
	end

	// final byte of the image ends the load
	// no write follows it, so reads see a settled map
	last_beat_ends_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_beat.valid && (i_beat.channel == chan_idx_t'(N_CHAN - 1))
			&& (i_beat.pixel == pix_idx_t'(N_PIX - 1))) |=> !i_beat.valid);

endmodule

// ==== design/op_controller.sv ====
`timescale 1ns/1ns

module op_controller #(
	parameter int ORIGIN_MAX = 6
) (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_op_valid,
	input  conv_op_pkg::op_mode_t   i_op_mode,
	input  logic                    i_in_valid,
	input  conv_geom_pkg::pixel_t   i_in_data,
	output logic                    o_op_ready,
	output logic                    o_in_ready,
	output conv_op_pkg::load_beat_t o_beat,
	output conv_op_pkg::conv_cmd_t  o_cmd,
	output conv_op_pkg::depth_t     o_depth,
	input  logic                    i_conv_done
);
	import conv_geom_pkg::*;
	import conv_op_pkg::*;

	ctrl_state_t state;
	logic        op_ready_q;
	logic [10:0] beat_cnt;
	pix_idx_t    org_q;
	depth_t      depth_q;
	logic        accept;
	logic        beat_take;
	logic        last_beat;

	// ------------------------------------------------------------
	// handshakes
	// ------------------------------------------------------------
	assign accept     = i_op_valid && op_ready_q;
	assign o_op_ready = op_ready_q;
	assign o_in_ready = (state == CTRL_LOAD);
	assign beat_take  = o_in_ready && i_in_valid;
	// 2048th byte closes the load
	assign last_beat  = beat_take && (beat_cnt == 11'h7ff);

	// channel-major order, low six bits walk the pixels
	assign o_beat.valid   = beat_take;
	assign o_beat.pixel   = pix_idx_t'(beat_cnt[5:0]);
	assign o_beat.channel = chan_idx_t'(beat_cnt[10:6]);
	assign o_beat.data    = i_in_data;
	assign o_depth        = depth_q;

	// ------------------------------------------------------------
	// command FSM
	// ------------------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= CTRL_IDLE;
			op_ready_q <= 1'b1;
			beat_cnt   <= '0;
			org_q      <= '0;
			depth_q    <= DEPTH_32;
			o_cmd      <= '0;
		end else begin
			// start is a single-cycle pulse
			o_cmd.start <= 1'b0;
			case (state)
				CTRL_IDLE: begin
					if (accept) begin
						op_ready_q <= 1'b0;
						case (i_op_mode)
							OP_LOAD: begin
								state <= CTRL_LOAD;
							end
							OP_CONV: begin
								state        <= CTRL_CONV_WAIT;
								o_cmd.start  <= 1'b1;
								o_cmd.origin <= org_q;
							end
							// moves stop at the image edge
							OP_RIGHT: begin
								if (org_q[2:0] < ORIGIN_MAX)
									org_q[2:0] <= org_q[2:0] + 3'd1;
							end
							OP_LEFT: begin
								if (org_q[2:0] != 3'd0)
									org_q[2:0] <= org_q[2:0] - 3'd1;
							end
							OP_UP: begin
								if (org_q[5:3] != 3'd0)
									org_q[5:3] <= org_q[5:3] - 3'd1;
							end
							OP_DOWN: begin
								if (org_q[5:3] < ORIGIN_MAX)
									org_q[5:3] <= org_q[5:3] + 3'd1;
							end
							// depth saturates at both ends
							OP_REDUCE_DEPTH: begin
								if (depth_q == DEPTH_32)
									depth_q <= DEPTH_16;
								else
									depth_q <= DEPTH_8;
							end
							OP_INCREASE_DEPTH: begin
								if (depth_q == DEPTH_8)
									depth_q <= DEPTH_16;
								else
									depth_q <= DEPTH_32;
							end
							default: ;
						endcase
					end else begin
						// shift, depth and unknown codes finish here
						op_ready_q <= 1'b1;
					end
				end
				CTRL_LOAD: begin
					if (beat_take)
						beat_cnt <= beat_cnt + 11'd1;
					if (last_beat) begin
						state      <= CTRL_IDLE;
						op_ready_q <= 1'b1;
					end
				end
				CTRL_CONV_WAIT: begin
					if (i_conv_done) begin
						state      <= CTRL_IDLE;
						op_ready_q <= 1'b1;
					end
				end
				default: state <= CTRL_IDLE;
			endcase
		end
	end

	// command and data phases never overlap
	ready_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_op_ready && o_in_ready));

	// window always fits inside the image
	origin_in_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(org_q[5:3] <= ORIGIN_MAX) && (org_q[2:0] <= ORIGIN_MAX));

endmodule

// ==== design/conv_op_pkg.sv ====
package conv_op_pkg;

	// command codes on i_op_mode
	// codes 8..15 are taken and ignored
	typedef enum logic [3:0] {
		OP_LOAD           = 4'd0,
		OP_RIGHT          = 4'd1,
		OP_LEFT           = 4'd2,
		OP_UP             = 4'd3,
		OP_DOWN           = 4'd4,
		OP_REDUCE_DEPTH   = 4'd5,
		OP_INCREASE_DEPTH = 4'd6,
		OP_CONV           = 4'd7
	} op_mode_t;

	// active channel count
	typedef enum logic [1:0] {
		DEPTH_8  = 2'd0,
		DEPTH_16 = 2'd1,
		DEPTH_32 = 2'd2
	} depth_t;

	// command FSM
	typedef enum logic [1:0] {CTRL_IDLE, CTRL_LOAD, CTRL_CONV_WAIT} ctrl_state_t;

	// convolution FSM
	typedef enum logic [1:0] {CONV_IDLE, CONV_TAP, CONV_EMIT} conv_state_t;

	// one accepted input byte with its position
	typedef struct packed {
		logic                     valid;
		conv_geom_pkg::pix_idx_t  pixel;
		conv_geom_pkg::chan_idx_t channel;
		conv_geom_pkg::pixel_t    data;
	} load_beat_t;

	// convolution start pulse and window origin
	typedef struct packed {
		logic                    start;
		conv_geom_pkg::pix_idx_t origin;
	} conv_cmd_t;

endpackage

// ==== design/conv_geom_pkg.sv ====
package conv_geom_pkg;

	// ------------------------------------------------------------
	// image geometry
	// ------------------------------------------------------------
	// square image, row-major pixel order
	localparam int IMG_SIDE = 8;
	localparam int N_PIX    = IMG_SIDE * IMG_SIDE;
	// channels sent one after another
	localparam int N_CHAN   = 32;

	// one input byte
	typedef logic [7:0]  pixel_t;
	// pixel index, row in [5:3], column in [2:0]
	typedef logic [5:0]  pix_idx_t;
	// channel index
	typedef logic [4:0]  chan_idx_t;

	// ------------------------------------------------------------
	// per-pixel sums
	// ------------------------------------------------------------
	// channels 0..7, at most 8 x 255
	typedef logic [10:0] grp8_sum_t;
	// channels 8..15, at most 8 x 255
	typedef logic [10:0] grp16_sum_t;
	// channels 16..31, at most 16 x 255
	typedef logic [11:0] grp32_sum_t;
	// all active groups added, at most 32 x 255
	typedef logic [12:0] map_sum_t;
	// weights add up to 16, so four more bits
	typedef logic [16:0] conv_acc_t;
	// weighted sum over 16, rounded
	typedef logic [12:0] out_data_t;

endpackage
